// ==== menuTop.f ====
menuPkg.sv
buttonDecoder.sv
menuNavigator.sv
menuRenderer.sv
menuTop.sv
menuTop_props.sv
menuTop_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the menu testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module menuTop_tb \
    -f menuTop.f \
    -o menuSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/menuSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit 1
fi

exit 0

// ==== menuTop_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module menuTop_tb import menuPkg::*;;

    localparam int        DEBOUNCE = 4;
    localparam pixelColor FG       = COLOR_WHITE;
    localparam pixelColor BG       = COLOR_BLACK;
    localparam int        BTN_UP   = 0;
    localparam int        BTN_DOWN = 1;
    localparam int        BTN_ENT  = 2;

    logic      clk = 1'b0;
    logic      rst;
    logic      btnUp;
    logic      btnDown;
    logic      btnEnter;
    logic      modeAck;
    pixelPos   pixelQuery;
    pixelColor pixelData;
    logic      modeReq;
    cursorPos  modeSel;
    cursorPos  activeMode;

    integer   seed = 15;
    string    testName = "none";
    cursorPos expCursor = '0;  // Model of the saturating cursor
    logic     reqPrev = 1'b0;
    int       reqCount = 0;    // Requests raised so far

    menuTop #(
        .DEBOUNCE_CYCLES (DEBOUNCE),
        .FG_COLOR        (FG),
        .BG_COLOR        (BG)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .btnUp      (btnUp),
        .btnDown    (btnDown),
        .btnEnter   (btnEnter),
        .pixelQuery (pixelQuery),
        .modeAck    (modeAck),
        .pixelData  (pixelData),
        .modeReq    (modeReq),
        .modeSel    (modeSel),
        .activeMode (activeMode)
    );

    always #5 clk = ~clk;

    // Counts every new request
    always @(posedge clk) begin
        reqPrev <= modeReq;
        if (modeReq && !reqPrev) begin
            reqCount <= reqCount + 1;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic failRun();
        $display("** FAIL **");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkColor(input string what, input pixelColor expected,
                              input pixelColor actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: %s expected %h, actual %h",
                     testName, what, expected, actual);
            failRun();
        end
    endtask

    task automatic checkCursor(input string what, input cursorPos expected,
                               input cursorPos actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: %s expected %0d, actual %0d",
                     testName, what, expected, actual);
            failRun();
        end
    endtask

    task automatic checkFlag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: %s expected %b, actual %b",
                     testName, what, expected, actual);
            failRun();
        end
    endtask

    task automatic expectPixel(input int x, input int y, input pixelColor expected);
        string where;
        where = $sformatf("pixel (%0d,%0d)", x, y);
        @(negedge clk);
        pixelQuery.x = pixelCoord'(x);
        pixelQuery.y = pixelCoord'(y);
        #1;  // Renderer is combinational
        checkColor(where, expected, pixelData);
    endtask

    // Empty band pixels, lit only for the highlighted entry
    task automatic checkBands();
        for (int k = 1; k <= 3; k++) begin
            expectPixel(90, 15 + 10 * k, (expCursor == cursorPos'(k)) ? FG : BG);
        end
    endtask

    ////////////////////////////////////////
    // Stimulus and application model
    ////////////////////////////////////////

    task automatic setButton(input int btn, input logic level);
        case (btn)
            BTN_UP:   btnUp = level;
            BTN_DOWN: btnDown = level;
            default:  btnEnter = level;
        endcase
    endtask

    // Short random bounce, steady hold, then release
    task automatic pressButton(input int btn, input int hold);
        logic [31:0] bounce;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            bounce = $random(seed);
            setButton(btn, bounce[0]);
        end
        @(negedge clk);
        setButton(btn, 1'b1);
        repeat (hold - 4) @(negedge clk);
        setButton(btn, 1'b0);
        repeat (12) @(negedge clk);
    endtask

    task automatic glitchButton(input int btn);
        @(negedge clk);
        setButton(btn, 1'b1);
        repeat (DEBOUNCE - 2) @(negedge clk);
        setButton(btn, 1'b0);
        repeat (12) @(negedge clk);
    endtask

    task automatic moveCursor(input int btn, input int hold);
        pressButton(btn, hold);
        if (btn == BTN_DOWN && expCursor != MENU_ITEMS) begin
            expCursor = expCursor + cursorPos'(1);
        end else if (btn == BTN_UP && expCursor != '0) begin
            expCursor = expCursor - cursorPos'(1);
        end
        checkCursor("cursor", expCursor, dut0.nav0.cursor);
    endtask

    task automatic waitForReq(input logic level, input int limit);
        int n;
        n = 0;
        while (modeReq !== level) begin
            if (n >= limit) begin
                $display("Timeout in %s: modeReq did not go to %b within %0d cycles",
                         testName, level, limit);
                failRun();
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    // Application side of the handshake
    task automatic ackRequest(input int delay);
        waitForReq(1'b1, 50);
        repeat (delay) @(negedge clk);
        modeAck = 1'b1;
        waitForReq(1'b0, 50);
        @(negedge clk);
        modeAck = 1'b0;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic testReset();
        testName = "reset state";
        checkFlag("modeReq", 1'b0, modeReq);
        checkCursor("activeMode", '0, activeMode);
        expectPixel(90, 25, BG);
        expectPixel(12, 22, FG);  // Label drawn normally
    endtask

    task automatic testNavigation();
        testName = "navigation";
        repeat (4) begin
            moveCursor(BTN_DOWN, 12);
            checkBands();
        end
        repeat (4) begin
            moveCursor(BTN_UP, 12);
            checkBands();
        end
    endtask

    task automatic testHighlight();
        testName = "highlight";
        moveCursor(BTN_DOWN, 12);
        expectPixel(12, 22, BG);
        expectPixel(3, 25, BG);   // Arrow cut out of the bar
        expectPixel(90, 22, FG);
        expectPixel(26, 5, FG);
        moveCursor(BTN_DOWN, 12);
        expectPixel(12, 22, FG);
        expectPixel(3, 25, BG);
        expectPixel(26, 5, FG);
    endtask

    task automatic testHandshake();
        testName = "handshake";
        pressButton(BTN_ENT, 12);
        waitForReq(1'b1, 20);
        checkCursor("modeSel", 2'd2, modeSel);
        ackRequest(4);
        checkFlag("modeReq", 1'b0, modeReq);
        checkCursor("activeMode", 2'd2, activeMode);
        repeat (2) @(negedge clk);
    endtask

    task automatic testIgnoredEnter();
        int startCount;
        testName = "ignored enter";
        moveCursor(BTN_UP, 12);
        moveCursor(BTN_UP, 12);
        startCount = reqCount;
        pressButton(BTN_ENT, 12);
        checkFlag("request at cursor 0", 1'b0, reqCount != startCount);
        moveCursor(BTN_DOWN, 12);
        pressButton(BTN_ENT, 12);
        waitForReq(1'b1, 20);
        checkCursor("modeSel", 2'd1, modeSel);
        moveCursor(BTN_DOWN, 12);
        checkCursor("modeSel after move", 2'd1, modeSel);
        pressButton(BTN_ENT, 12);   // Busy, so ignored
        checkFlag("modeReq", 1'b1, modeReq);
        checkCursor("modeSel after busy enter", 2'd1, modeSel);
        ackRequest(3);
        checkCursor("activeMode", 2'd1, activeMode);
        startCount = reqCount;
        repeat (10) @(negedge clk);
        checkFlag("queued request", 1'b0, reqCount != startCount);
    endtask

    task automatic testDebounce();
        int startCount;
        testName = "debounce";
        moveCursor(BTN_UP, 40);   // Long hold, one step
        glitchButton(BTN_UP);
        checkCursor("cursor after glitch", expCursor, dut0.nav0.cursor);
        startCount = reqCount;
        glitchButton(BTN_ENT);
        checkFlag("request after glitch", 1'b0, reqCount != startCount);
    endtask

    initial begin
        rst        = 1'b1;
        btnUp      = 1'b0;
        btnDown    = 1'b0;
        btnEnter   = 1'b0;
        modeAck    = 1'b0;
        pixelQuery = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        testReset();
        testNavigation();
        testHighlight();
        testHandshake();
        testIgnoredEnter();
        testDebounce();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== menuTop_props.sv ====
`timescale 1ns/100ps
`default_nettype none

// Handshake and event pulse rules, checked inside the navigator
module handshakeProps import menuPkg::*; (
    input wire      clk,
    input wire      rst,
    input btnEvents events,
    input wire      modeAck,
    input wire      modeReq,
    input cursorPos modeSel
);

    ////////////////////////////////////////
    // Four-phase handshake
    ////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        (modeReq && $past(modeReq)) |-> $stable(modeSel))
        else $error("modeSel changed while modeReq was high");

    // Request only drops after the ack was seen
    assert property (@(posedge clk) disable iff (rst)
        $fell(modeReq) |-> $past(modeAck))
        else $error("modeReq fell before modeAck was high");

    ////////////////////////////////////////
    // Event pulses one cycle wide
    ////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst) events.up |=> !events.up)
        else $error("up event lasted more than one cycle");

    assert property (@(posedge clk) disable iff (rst) events.down |=> !events.down)
        else $error("down event lasted more than one cycle");

endmodule

bind menuNavigator handshakeProps props0 (
    .clk     (clk),
    .rst     (rst),
    .events  (events),
    .modeAck (modeAck),
    .modeReq (modeReq),
    .modeSel (modeSel)
);

`default_nettype wire

// ==== menuTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module menuTop import menuPkg::*; #(
    parameter int        DEBOUNCE_CYCLES = 4,
    parameter pixelColor FG_COLOR        = COLOR_WHITE,
    parameter pixelColor BG_COLOR        = COLOR_BLACK
) (
    input  wire       clk,
    input  wire       rst,
    input  wire       btnUp,
    input  wire       btnDown,
    input  wire       btnEnter,
    input  pixelPos   pixelQuery,
    input  wire       modeAck,
    output pixelColor pixelData,
    output logic      modeReq,
    output cursorPos  modeSel,
    output cursorPos  activeMode
);

    btnEvents events;
    cursorPos cursor;

    buttonDecoder #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) decoder0 (
        .clk      (clk),
        .rst      (rst),
        .btnUp    (btnUp),
        .btnDown  (btnDown),
        .btnEnter (btnEnter),
        .events   (events)
    );

    menuNavigator nav0 (
        .clk        (clk),
        .rst        (rst),
        .events     (events),
        .modeAck    (modeAck),
        .cursor     (cursor),
        .modeReq    (modeReq),
        .modeSel    (modeSel),
        .activeMode (activeMode)
    );

    menuRenderer #(
        .FG_COLOR (FG_COLOR),
        .BG_COLOR (BG_COLOR)
    ) render0 (
        .pixelQuery (pixelQuery),
        .cursor     (cursor),
        .pixelData  (pixelData)
    );

endmodule

`default_nettype wire

// ==== menuRenderer.sv ====
`timescale 1ns/100ps
`default_nettype none

// Pure combinational pixel lookup for the main menu screen
module menuRenderer import menuPkg::*; #(
    parameter pixelColor FG_COLOR = COLOR_WHITE,
    parameter pixelColor BG_COLOR = COLOR_BLACK
) (
    input  pixelPos   pixelQuery,
    input  cursorPos  cursor,
    output pixelColor pixelData
);

    int xi;
    int yi;

    logic titleM;
    logic titleE;
    logic titleN;
    logic titleU;
    logic title;
    logic volBar;
    logic pingPong;
    logic waveLbl;
    logic lit;

    logic [MENU_ITEMS:1] label;
    logic [MENU_ITEMS:1] band;
    logic [MENU_ITEMS:1] arrow;

    assign xi = int'(pixelQuery.x);
    assign yi = int'(pixelQuery.y);

    ////////////////////////////////////////
    // Glyph helpers
    ////////////////////////////////////////

    function automatic logic span(input int v, input int lo, input int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    // Small 7-row letters, dx and dy from the top left corner
    function automatic logic glyphV(input int dx, input int dy);
        return ((dx == 0 || dx == 4) && span(dy, 0, 4))
            || (dy == 5 && (dx == 1 || dx == 3)) || (dx == 2 && dy == 6);
    endfunction

    function automatic logic glyphO(input int dx, input int dy);
        return ((dx == 0 || dx == 4) && span(dy, 1, 5))
            || (span(dx, 1, 3) && (dy == 0 || dy == 6));
    endfunction

    function automatic logic glyphL(input int dx, input int dy);
        return (dx == 0 && span(dy, 0, 6)) || (span(dx, 1, 3) && dy == 6);
    endfunction

    function automatic logic glyphU(input int dx, input int dy);
        return ((dx == 0 || dx == 3) && span(dy, 0, 5)) || (span(dx, 1, 2) && dy == 6);
    endfunction

    function automatic logic glyphM(input int dx, input int dy);
        return ((dx == 0 || dx == 4) && span(dy, 0, 6))
            || (dy == 1 && (dx == 1 || dx == 3)) || (dx == 2 && dy == 2);
    endfunction

    function automatic logic glyphE(input int dx, input int dy, input int w);
        return (dx == 0 && span(dy, 0, 6))
            || (span(dx, 0, w) && (dy == 0 || dy == 3 || dy == 6));
    endfunction

    function automatic logic glyphB(input int dx, input int dy);
        return (dx == 0 && span(dy, 0, 6))
            || (span(dx, 0, 2) && (dy == 0 || dy == 3 || dy == 6))
            || (dx == 3 && (span(dy, 1, 2) || span(dy, 4, 5)));
    endfunction

    function automatic logic glyphA(input int dx, input int dy);
        return (dx == 4 && span(dy, 0, 6)) || (dx == 0 && span(dy, 3, 6))
            || (span(dx, 1, 3) && dy == 4)
            || (span(dx, 1, 3) && (dx + dy == 3));  // Rising stroke
    endfunction

    function automatic logic glyphR(input int dx, input int dy);
        return (dx == 0 && span(dy, 0, 6))
            || (span(dx, 0, 2) && (dy == 0 || dy == 3))
            || (dx == 3 && span(dy, 1, 2))
            || (span(dy, 4, 6) && dx == dy - 2);  // Leg
    endfunction

    function automatic logic glyphP(input int dx, input int dy);
        return (dx == 0 && span(dy, 0, 6))
            || (span(dx, 1, 2) && (dy == 0 || dy == 3))
            || (dx == 3 && span(dy, 1, 2));
    endfunction

    function automatic logic glyphN(input int dx, input int dy);
        return ((dx == 0 || dx == 4) && span(dy, 0, 6)) || (span(dx, 1, 3) && dy == dx + 1);
    endfunction

    function automatic logic glyphG(input int dx, input int dy);
        return (dx == 0 && span(dy, 1, 5))
            || (span(dx, 1, 2) && (dy == 0 || dy == 6))
            || (dx == 3 && (dy == 1 || dy == 5))
            || (dx == 4 && span(dy, 5, 6));
    endfunction

    function automatic logic glyphW(input int dx, input int dy);
        return ((dx == 0 || dx == 3 || dx == 6) && span(dy, 0, 5))
            || ((dx == 1 || dx == 2 || dx == 4 || dx == 5) && dy == 6);
    endfunction

    // Right pointing triangle, 5 rows tall
    function automatic logic arrowAt(input int x, input int y, input int centre);
        int dy;
        dy = y - centre;
        return (x == 3 && span(dy, -2, 2)) || (x == 4 && (dy == -2 || dy == 2))
            || (x == 5 && (dy == -1 || dy == 1)) || (x == 6 && dy == 0);
    endfunction

    ////////////////////////////////////////
    // Title MENU, two pixel strokes
    ////////////////////////////////////////

    assign titleM = ((span(xi, 26, 27) || span(xi, 38, 39)) && span(yi, 3, 16))
        || (span(xi, 28, 31) && span(yi - xi + 23, 0, 1))   // Left diagonal
        || (span(xi, 32, 33) && span(yi, 9, 10))
        || (span(xi, 34, 37) && span(yi + xi - 42, 0, 1));  // Right diagonal

    assign titleE = (span(xi, 42, 43) && span(yi, 3, 16))
        || (span(xi, 44, 49) && (span(yi, 3, 4) || span(yi, 9, 10) || span(yi, 15, 16)));

    assign titleN = ((span(xi, 52, 53) || span(xi, 60, 61)) && span(yi, 3, 16))
        || (span(xi, 53, 58) && span(yi - xi + 47, 0, 1));

    assign titleU = ((span(xi, 64, 65) || span(xi, 70, 71)) && span(yi, 3, 14))
        || (span(xi, 66, 69) && span(yi, 15, 16));

    assign title = titleM || titleE || titleN || titleU;

    ////////////////////////////////////////
    // Entry labels
    ////////////////////////////////////////

    assign volBar = glyphV(xi - 12, yi - 22) || glyphO(xi - 18, yi - 22)
        || glyphL(xi - 24, yi - 22) || glyphU(xi - 29, yi - 22)
        || glyphM(xi - 34, yi - 22) || glyphE(xi - 40, yi - 22, 2)
        || glyphB(xi - 47, yi - 22) || glyphA(xi - 52, yi - 22)
        || glyphR(xi - 58, yi - 22);

    assign pingPong = glyphP(xi - 12, yi - 32) || (xi == 17 && span(yi, 32, 38))  // I
        || glyphN(xi - 19, yi - 32) || glyphG(xi - 25, yi - 32)
        || glyphP(xi - 33, yi - 32) || glyphO(xi - 38, yi - 32)
        || glyphN(xi - 44, yi - 32) || glyphG(xi - 50, yi - 32);

    assign waveLbl = glyphW(xi - 12, yi - 42) || glyphA(xi - 20, yi - 42)
        || glyphV(xi - 26, yi - 42) || glyphE(xi - 32, yi - 42, 3);

    assign label = {waveLbl, pingPong, volBar};

    // Selection bands and arrows, entry k centred on row 15+10k
    genvar k;
    generate
        for (k = 1; k <= MENU_ITEMS; k++) begin : gEntry
            assign band[k]  = span(yi, 11 + 10 * k, 19 + 10 * k) && span(xi, 0, 95);
            assign arrow[k] = arrowAt(xi, yi, 15 + 10 * k);
        end
    endgenerate

    // Highlighted entry is drawn inverted
    always_comb begin
        lit = title;
        for (int e = 1; e <= MENU_ITEMS; e++) begin
            if (cursor == cursorPos'(e)) begin
                lit = lit || (band[e] && !label[e] && !arrow[e]);
            end else begin
                lit = lit || label[e];
            end
        end
    end

    assign pixelData = lit ? FG_COLOR : BG_COLOR;

endmodule

`default_nettype wire

// ==== menuNavigator.sv ====
`timescale 1ns/100ps
`default_nettype none

module menuNavigator import menuPkg::*; (
    input  wire      clk,
    input  wire      rst,
    input  btnEvents events,
    input  wire      modeAck,
    output cursorPos cursor,
    output logic     modeReq,
    output cursorPos modeSel,
    output cursorPos activeMode
);

    hsState hsCur;
    hsState hsNext;
    logic   stepUp;
    logic   stepDown;
    logic   startReq;
    logic   commit;

    ////////////////////////////////////////
    // Cursor
    ////////////////////////////////////////

    // Both buttons at once cancel out
    assign stepUp   = events.up && !events.down && (cursor != '0);
    assign stepDown = events.down && !events.up && (cursor != MENU_ITEMS);

    always_ff @(posedge clk) begin
        if (rst) begin
            cursor <= '0;
        end else if (stepUp) begin
            cursor <= cursor - cursorPos'(1);
        end else if (stepDown) begin
            cursor <= cursor + cursorPos'(1);
        end
    end

    ////////////////////////////////////////
    // Mode handshake
    ////////////////////////////////////////

    // Enter on a real entry while the ack line is quiet
    assign startReq = events.enter && (cursor != '0) && !modeAck;

    always_comb begin
        hsNext = hsCur;
        case (hsCur)
            HS_IDLE: begin
                if (startReq) begin
                    hsNext = HS_REQ;
                end
            end
            HS_REQ: begin
                if (modeAck) begin
                    hsNext = HS_RELEASE;
                end
            end
            HS_RELEASE: begin
                if (!modeAck) begin
                    hsNext = HS_IDLE;
                end
            end
            default: hsNext = HS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hsCur <= HS_IDLE;
        end else begin
            hsCur <= hsNext;
        end
    end

    assign commit  = (hsCur == HS_REQ) && modeAck;
    assign modeReq = (hsCur == HS_REQ);

    // Selection frozen for the whole request
    always_ff @(posedge clk) begin
        if ((hsCur == HS_IDLE) && startReq) begin
            modeSel <= cursor;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            activeMode <= '0;
        end else if (commit) begin
            activeMode <= modeSel;  // Takes effect as modeReq falls
        end
    end

endmodule

`default_nettype wire

// ==== buttonDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

// Three identical button channels
// Each one is sync, debounce and rising edge detect
module buttonDecoder import menuPkg::*; #(
    parameter int DEBOUNCE_CYCLES = 4
) (
    input  wire      clk,
    input  wire      rst,
    input  wire      btnUp,
    input  wire      btnDown,
    input  wire      btnEnter,
    output btnEvents events
);

    localparam int NUM_BTN = 3;
    localparam int CNT_W   = $clog2(DEBOUNCE_CYCLES + 1);

    logic [NUM_BTN-1:0] rawBtn;
    logic [NUM_BTN-1:0] rise;

    assign rawBtn = {btnEnter, btnDown, btnUp};

    genvar i;
    generate
        for (i = 0; i < NUM_BTN; i++) begin : gChan
            logic [1:0]       syncReg;    // Two-flop synchroniser
            logic [CNT_W-1:0] stableCnt;  // Cycles the new level has held
            logic             debLevel;
            logic             pulse;

            always_ff @(posedge clk) begin
                if (rst) begin
                    syncReg   <= '0;
                    stableCnt <= '0;
                    debLevel  <= 1'b0;
                    pulse     <= 1'b0;
                end else begin
                    syncReg <= {syncReg[0], rawBtn[i]};
                    pulse   <= 1'b0;

                    if (syncReg[1] == debLevel) begin
                        stableCnt <= '0;  // Bounce back restarts the count
                    end else if (stableCnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                        stableCnt <= '0;
                        debLevel  <= syncReg[1];
                        pulse     <= syncReg[1];  // Press only, not release
                    end else begin
                        stableCnt <= stableCnt + CNT_W'(1);
                    end
                end
            end

            assign rise[i] = pulse;
        end
    endgenerate

    // Channel order matches rawBtn
    assign events.up    = rise[0];
    assign events.down  = rise[1];
    assign events.enter = rise[2];

endmodule

`default_nettype wire

// ==== menuPkg.sv ====
`default_nettype none

package menuPkg;

    ////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////

    typedef logic [6:0]  pixelCoord;   // OLED column 0..95 or row 0..63
    typedef logic [15:0] pixelColor;   // RGB565
    typedef logic [1:0]  cursorPos;    // 0 is no highlight, 1..3 the entries

    // Highest valid cursor value
    localparam cursorPos MENU_ITEMS = 2'd3;

    localparam pixelColor COLOR_WHITE = 16'hFFFF;
    localparam pixelColor COLOR_BLACK = 16'h0000;

    ////////////////////////////////////////
    // Bundles between blocks
    ////////////////////////////////////////

    // Pixel query from the OLED driver
    typedef struct packed {
        pixelCoord x;
        pixelCoord y;
    } pixelPos;

    // One-cycle button events
    typedef struct packed {
        logic up;
        logic down;
        logic enter;
    } btnEvents;

    // Mode handshake towards the application
    typedef enum logic [1:0] {
        HS_IDLE    = 2'd0,  // Free for a new request
        HS_REQ     = 2'd1,  // modeReq high, waiting for ack
        HS_RELEASE = 2'd2   // Request dropped, waiting for ack low
    } hsState;

endpackage

`default_nettype wire
